//--- Bender.yml
package:
  name: besm_exec

export_include_dirs:
  - include

sources:
  # packages first, then the datapath blocks and the top level
  - files:
      - source/besm_types_pkg.sv
      - source/besm_ops_pkg.sv
      - source/shifter.sv
      - source/logic_unit.sv
      - source/accumulator.sv
      - source/besm_exec_top.sv

  - target: test
    files:
      - bench/tb_besm_exec.sv

//--- bench/tb_besm_exec.sv
/*
 * testbench for the micro-BESM execution core
 * random and directed commands against a bench model, checked by assertions
 */
`timescale 1ns/1ns
`include "besm_settings.svh"

module tb_besm_exec
    import besm_types_pkg::*;
    import besm_ops_pkg::*;
;
    localparam int CLK_PERIOD = 8;
    localparam int W          = `BESM_WORD_WIDTH;
    localparam int RIGHT_REPS = 6;  // load and shift pairs per right mode
    localparam int LEFT_REPS  = 4;
    localparam int LOGIC_REPS = 4;
    // strobes issued over the whole run, phase by phase
    localparam int N_CMDS = 4*RIGHT_REPS*2 + 4 + 3*LEFT_REPS*2 + 14 + 4*LOGIC_REPS*2 + 2 + 6;

    logic    clk = 1'b0;
    logic    rst;
    logic    cmd_strobe;
    cmd_t    cmd;
    word_t   operand;
    word_t   acc;
    status_t status;
    logic    done;

    word_t   model_acc;             // bench copy of the accumulator
    status_t model_status;
    word_t   ref_next;
    logic    ref_carry;
    string   name_in;               // test name travelling with the command
    string   stage_name;
    string   chk_name;              // name of the result being checked
    int      fail_count = 0;
    int      seed_dummy;

    besm_exec_top dut (
        .clk        (clk),
        .rst        (rst),
        .cmd_strobe (cmd_strobe),
        .cmd        (cmd),
        .operand    (operand),
        .acc        (acc),
        .status     (status),
        .done       (done)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic word_t rand_word();
        return {$urandom, $urandom};
    endfunction

    // barrel shifter rules, bit by bit
    function automatic word_t ref_shift(word_t v, logic psel, shamt_t p, wide_shamt_t wf,
                                        shift_mode_e md);
        word_t r;
        logic  right;
        int    cnt;
        int    k;
        r = '0;
        if (psel) begin
            right = p[6];
            cnt   = p[5:0];
            if (!right)
                cnt = (64 - cnt) % 64;      // left counts are negated mod 64
        end else begin
            right = wf[10];
            cnt   = wf[6:0];
            if (!right)
                cnt = (128 - cnt) % 128;    // 7-bit negate for the wide field
        end
        k = cnt % 64;
        for (int i = 0; i < W; i++) begin
            if (right) begin
                case (md)
                    SH_CYCLIC: r[i] = v[(i + k) % 64];
                    SH_ARITH:  r[i] = (i + cnt < W) ? v[i + cnt] : v[W-1];
                    default:   r[i] = (i + cnt < W) ? v[i + cnt] : 1'b0;
                endcase
            end else begin
                case (md)
                    SH_CYCLIC: r[i] = v[(i - k + 64) % 64];
                    default:   r[i] = (i >= cnt) ? v[i - cnt] : 1'b0;
                endcase
            end
        end
        if (!right && md == SH_ARITH)
            r[W-1] = v[W-1];                // sign stays put
        if (right && md == SH_CONVERT) begin
            r[W-1]       = v[W-1];
            r[W-2:W-5]   = {4{~v[W-1]}};    // exponent guard bits
        end
        return r;
    endfunction

    function automatic word_t ref_logic(word_t a, word_t b, logic_op_e op, output logic c);
        logic [W:0] s;
        s = {1'b0, a} + {1'b0, b};
        c = 1'b0;
        case (op)
            LG_AND: return a & b;
            LG_OR:  return a | b;
            LG_XOR: return a ^ b;
            LG_ADD: begin
                c = s[W];
                return s[W-1:0];
            end
            default: return b;
        endcase
    endfunction

    function automatic cmd_t shift_cmd(shift_mode_e md, logic psel, shamt_t p);
        cmd_t c;
        c.is_shift = 1'b1;
        c.psel     = psel;
        c.mode     = md;
        c.lop      = LG_LOAD;
        c.param    = p;
        return c;
    endfunction

    function automatic cmd_t logic_cmd(logic_op_e op);
        cmd_t c;
        c.is_shift = 1'b0;
        c.psel     = 1'b1;
        c.mode     = SH_CYCLIC;
        c.lop      = op;
        c.param    = shamt_t'($urandom);  // ignored by the logic path
        return c;
    endfunction

    // model register, updated from the same sampled inputs as the DUT
    always @(posedge clk) begin
        if (rst) begin
            model_acc    <= '0;
            model_status <= '{zero: 1'b1, sign: 1'b0, carry: 1'b0};
        end else if (cmd_strobe) begin
            if (cmd.is_shift) begin
                ref_next  = ref_shift(model_acc, cmd.psel, cmd.param, operand[10:0], cmd.mode);
                ref_carry = 1'b0;
            end else begin
                ref_next = ref_logic(model_acc, operand, cmd.lop, ref_carry);
            end
            model_acc    <= ref_next;
            model_status <= '{zero: (ref_next == '0), sign: ref_next[W-1], carry: ref_carry};
            stage_name   <= name_in;
        end
        chk_name <= stage_name;     // lines up with the check one cycle later
    end

    task automatic report_mismatch(string name, logic [W-1:0] exp, logic [W-1:0] act);
        $display("mismatch %s: expected %h actual %h", name, exp, act);
        $display("=== FAIL ===");
        fail_count++;
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(string msg);
        $display("error: %s", msg);
        $display("=== FAIL ===");
        fail_count++;
        $fatal(1, "stopped at first error");
    endtask

    a_reset_state: assert property (@(posedge clk)
        $fell(rst) |-> (acc == '0 && status.zero && !status.sign && !status.carry && !done))
        else report_failure("acc or status not cleared by reset");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> (done == $past(cmd_strobe)))
        else report_failure("done is not a one cycle echo of the strobe");

    a_acc_result: assert property (@(posedge clk) disable iff (rst)
        cmd_strobe |=> (acc == model_acc))
        else report_mismatch(chk_name, $sampled(model_acc), $sampled(acc));

    a_status_result: assert property (@(posedge clk) disable iff (rst)
        cmd_strobe |=> (status == model_status))
        else report_mismatch({chk_name, " status"}, W'($sampled(model_status)),
                             W'($sampled(status)));

    a_acc_idle: assert property (@(posedge clk) disable iff (rst)
        !cmd_strobe |=> ($stable(acc) && $stable(status)))
        else report_failure("acc or status changed in an idle cycle");

    // one strobe per call, back to back when called in a row
    task automatic send(cmd_t c, word_t op, string name);
        @(posedge clk);
        cmd_strobe <= 1'b1;
        cmd        <= c;
        operand    <= op;
        name_in    <= name;
    endtask

    task automatic go_idle(int cycles);
        repeat (cycles) begin
            @(posedge clk);
            cmd_strobe <= 1'b0;
            operand    <= rand_word();  // noise on the bus must not leak in
        end
    endtask

    // load a word, then shift it by a wide count carried in the operand
    task automatic wide_case(shift_mode_e md, logic right, int cnt, logic neg, string name);
        word_t data;
        word_t op;
        data      = rand_word();
        data[W-1] = neg;
        op        = rand_word();
        op[10]    = right;
        op[6:0]   = 7'(cnt);
        send(logic_cmd(LG_LOAD), data, "wide load");
        send(shift_cmd(md, 1'b0, shamt_t'($urandom)), op, name);
    endtask

    initial begin
        word_t       data;
        shift_mode_e md;
        logic_op_e   op;
        seed_dummy = $urandom(3);
        rst        = 1'b1;
        cmd_strobe = 1'b0;
        cmd        = '0;
        operand    = '0;
        name_in    = "none";
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        go_idle(3);                 // done must stay low here

        // right shifts, short field, all four modes
        for (int m = 0; m < 4; m++) begin
            md = shift_mode_e'(m);
            for (int i = 0; i < RIGHT_REPS; i++) begin
                data      = rand_word();
                data[W-1] = i[0];   // every other word negative
                send(logic_cmd(LG_LOAD), data, "load");
                send(shift_cmd(md, 1'b1, {1'b1, 6'($urandom_range(63, 0))}), rand_word(),
                     $sformatf("right %s", md.name()));
            end
        end
        send(logic_cmd(LG_LOAD), 64'h8000_0000_0000_0001, "load");
        send(shift_cmd(SH_ARITH, 1'b1, 7'h7f), rand_word(), "right arith by 63");
        send(logic_cmd(LG_LOAD), 64'hf0f0_1234_5678_9abc, "load");
        send(shift_cmd(SH_CONVERT, 1'b1, 7'h45), rand_word(), "convert negative");
        go_idle(2);

        // left shifts, short field
        for (int m = 0; m < 3; m++) begin
            md = shift_mode_e'(m);
            for (int i = 0; i < LEFT_REPS; i++) begin
                data      = rand_word();
                data[W-1] = ~i[0];
                send(logic_cmd(LG_LOAD), data, "load");
                send(shift_cmd(md, 1'b1, {1'b0, 6'($urandom_range(63, 0))}), rand_word(),
                     $sformatf("left %s", md.name()));
            end
        end
        go_idle(2);

        // wide field from the operand, counts past the word width
        wide_case(SH_ARITH,   1'b1, 64,  1'b1, "wide right arith 64");
        wide_case(SH_ARITH,   1'b1, 100, 1'b1, "wide right arith 100");
        wide_case(SH_LOGICAL, 1'b1, 64,  1'b0, "wide right logical 64");
        wide_case(SH_LOGICAL, 1'b1, 127, 1'b1, "wide right logical 127");
        wide_case(SH_CONVERT, 1'b1, 80,  1'b1, "wide convert 80");
        wide_case(SH_CYCLIC,  1'b0, 20,  1'b0, "wide left cyclic");
        wide_case(SH_ARITH,   1'b0, 120, 1'b1, "wide left arith");
        go_idle(2);

        // logic and add against random operands
        for (int o = 1; o < 5; o++) begin
            op = logic_op_e'(o);
            for (int i = 0; i < LOGIC_REPS; i++) begin
                send(logic_cmd(LG_LOAD), rand_word(), "load");
                send(logic_cmd(op), rand_word(), $sformatf("logic %s", op.name()));
            end
        end
        send(logic_cmd(LG_LOAD), '1, "load ones");
        send(logic_cmd(LG_ADD), 64'd1, "add carry out");   // wraps to zero
        go_idle(2);

        // back to back, then holds through gaps
        send(logic_cmd(LG_LOAD), rand_word(), "b2b load");
        send(logic_cmd(LG_ADD), rand_word(), "b2b add");
        send(logic_cmd(LG_XOR), rand_word(), "b2b xor");
        send(shift_cmd(SH_CYCLIC, 1'b1, 7'h48), rand_word(), "b2b rotate");
        go_idle(5);
        send(logic_cmd(LG_OR), rand_word(), "gap or");
        go_idle(3);
        send(shift_cmd(SH_LOGICAL, 1'b1, 7'h3c), rand_word(), "gap left");
        go_idle(3);

        if (fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "checks failed");
        end
    end

    // watchdog sized from the command count
    initial begin
        #((N_CMDS + 100) * CLK_PERIOD);
        $display("error: run did not finish in time");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- include/besm_settings.svh
/*
 * micro-BESM execution core settings
 * word and shift field widths fixed by the machine format
 */
`ifndef BESM_SETTINGS_SVH
`define BESM_SETTINGS_SVH

// full machine word
`define BESM_WORD_WIDTH  64
`define BESM_SHAMT_WIDTH 7   // short shift field carried in the command
`define BESM_WIDE_WIDTH  11  // wide shift field in low operand bits

`endif

//--- sim.f
+incdir+include
source/besm_types_pkg.sv
source/besm_ops_pkg.sv
source/shifter.sv
source/logic_unit.sv
source/accumulator.sv
source/besm_exec_top.sv
bench/tb_besm_exec.sv

//--- source/accumulator.sv
/*
 * micro-BESM accumulator
 * result select, writeback on strobe, done pulse and flags
 */
`timescale 1ns/1ns

module accumulator
    import besm_types_pkg::*;
    import besm_ops_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    strobe,         // one command this cycle
    input  logic    is_shift,
    input  word_t   shift_result,
    input  word_t   logic_result,
    input  logic    logic_carry,
    output word_t   acc,
    output status_t status,
    output logic    done
);
    word_t   next_acc;
    status_t next_status;

    assign next_acc = is_shift ? shift_result : logic_result;

    // flags come from the value about to be written
    always_comb begin
        next_status.zero  = (next_acc == '0);
        next_status.sign  = next_acc[$bits(word_t)-1];
        next_status.carry = is_shift ? 1'b0 : logic_carry;  // shifts clear carry
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc    <= '0;
            status <= '{zero: 1'b1, sign: 1'b0, carry: 1'b0};
            done   <= 1'b0;
        end else begin
            done <= strobe;         // single cycle pulse
            if (strobe) begin
                acc    <= next_acc;
                status <= next_status;
            end
        end
    end

    // done is the strobe delayed by one clock
    a_done_follows: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> (done == $past(strobe)));

    // no strobe, no change to acc or flags
    a_acc_hold: assert property (@(posedge clk) disable iff (rst)
        !strobe |=> ($stable(acc) && $stable(status)));

    // zero flag tracks the stored word
    a_zero_flag: assert property (@(posedge clk) disable iff (rst)
        status.zero == (acc == '0));

endmodule

//--- source/besm_exec_top.sv
/*
 * micro-BESM execution core
 * routes a command to shifter and logic unit, result into acc
 */
`timescale 1ns/1ns

module besm_exec_top
    import besm_types_pkg::*;
    import besm_ops_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    cmd_strobe,
    input  cmd_t    cmd,            // valid with cmd_strobe
    input  word_t   operand,
    output word_t   acc,
    output status_t status,
    output logic    done
);
    word_t       shift_out;
    word_t       logic_out;
    logic        logic_carry;
    wide_shamt_t wide_param;        // low operand bits

    assign wide_param = operand[$bits(wide_shamt_t)-1:0];

    // shifter always works on the current acc
    shifter u_shifter (
        .in         (acc),
        .psel       (cmd.psel),
        .param      (cmd.param),
        .wide_param (wide_param),
        .mode       (cmd.mode),
        .out        (shift_out)
    );

    logic_unit u_logic (
        .a      (acc),
        .b      (operand),
        .lop    (cmd.lop),
        .result (logic_out),
        .carry  (logic_carry)
    );

    accumulator u_acc (
        .clk          (clk),
        .rst          (rst),
        .strobe       (cmd_strobe),
        .is_shift     (cmd.is_shift),
        .shift_result (shift_out),
        .logic_result (logic_out),
        .logic_carry  (logic_carry),
        .acc          (acc),
        .status       (status),
        .done         (done)
    );

endmodule

//--- source/besm_ops_pkg.sv
/*
 * micro-BESM operation encodings
 * shift modes, logic ops, command and status records
 */
`include "besm_settings.svh"

package besm_ops_pkg;
    import besm_types_pkg::*;

    // same codes as the shifter op field
    typedef enum logic [1:0] {
        SH_CYCLIC  = 2'd0,
        SH_LOGICAL = 2'd1,
        SH_ARITH   = 2'd2,
        SH_CONVERT = 2'd3   // to BESM-6 float layout
    } shift_mode_e;

    typedef enum logic [2:0] {
        LG_LOAD = 3'd0,     // acc takes operand
        LG_AND  = 3'd1,
        LG_OR   = 3'd2,
        LG_XOR  = 3'd3,
        LG_ADD  = 3'd4
    } logic_op_e;

    typedef struct packed {
        logic        is_shift;  // shifter vs logic unit
        logic        psel;      // short field selects the count
        shift_mode_e mode;
        logic_op_e   lop;
        shamt_t      param;
    } cmd_t;

    typedef struct packed {
        logic zero;
        logic sign;
        logic carry;            // add carry out only
    } status_t;

    // direction bits of the two shift fields
    function automatic logic short_right(shamt_t p);
        return p[`BESM_SHAMT_WIDTH-1];
    endfunction

    function automatic logic wide_right(wide_shamt_t p);
        return p[`BESM_WIDE_WIDTH-1];
    endfunction

endpackage

//--- source/besm_types_pkg.sv
/*
 * micro-BESM data types
 * plain vector types for words and shift fields
 */
`include "besm_settings.svh"

package besm_types_pkg;

    // one machine word with the sign in bit 63
    typedef logic [`BESM_WORD_WIDTH-1:0] word_t;

    // short field from the command
    // top bit set means shift right, low 6 bits hold the count
    typedef logic [`BESM_SHAMT_WIDTH-1:0] shamt_t;

    // wide field from the operand
    // top bit is the direction, bits 6..0 the count
    typedef logic [`BESM_WIDE_WIDTH-1:0] wide_shamt_t;

endpackage

//--- source/logic_unit.sv
/*
 * micro-BESM logic and add unit
 * combines accumulator with operand, carry out on add
 */
`timescale 1ns/1ns

module logic_unit
    import besm_types_pkg::*;
    import besm_ops_pkg::*;
(
    input  word_t     a,        // accumulator
    input  word_t     b,        // operand
    input  logic_op_e lop,
    output word_t     result,
    output logic      carry
);
    localparam int W = $bits(word_t);

    logic [W:0] sum;            // one extra bit for carry

    assign sum = {1'b0, a} + {1'b0, b};

    always_comb begin
        result = b;
        carry  = 1'b0;
        case (lop)
            LG_LOAD: result = b;
            LG_AND:  result = a & b;
            LG_OR:   result = a | b;
            LG_XOR:  result = a ^ b;
            LG_ADD: begin
                result = sum[W-1:0];
                carry  = sum[W];
            end
            default: result = b;    // unused codes act as load
        endcase
    end

endmodule

//--- source/shifter.sv
/*
 * micro-BESM barrel shifter
 * cyclic, logical, arithmetic and format conversion shifts
 */
`timescale 1ns/1ns
`include "besm_settings.svh"

module shifter
    import besm_types_pkg::*;
    import besm_ops_pkg::*;
(
    input  word_t       in,
    input  logic        psel,       // 1 picks the short field
    input  shamt_t      param,
    input  wide_shamt_t wide_param,
    input  shift_mode_e mode,
    output word_t       out
);
    localparam int W  = `BESM_WORD_WIDTH;
    localparam int CW = `BESM_SHAMT_WIDTH;

    logic              right;       // shift direction
    logic [CW-1:0]     n;           // effective shift count
    logic [CW-2:0]     short_cnt;
    logic [2*W-1:0]    dbl;         // double word for rotate and sign fill
    word_t             tmp;

    assign right     = psel ? short_right(param) : wide_right(wide_param);
    assign short_cnt = param[CW-2:0];

    // left counts come negated in the machine encoding
    always_comb begin
        if (psel)
            n = right ? {1'b0, short_cnt} : {1'b0, -short_cnt};
        else
            n = right ? wide_param[CW-1:0] : -wide_param[CW-1:0];
    end

    always_comb begin
        dbl = '0;
        tmp = '0;
        out = '0;
        if (right) begin
            case (mode)
                SH_CYCLIC: begin
                    dbl = {in, in} >> n[CW-2:0];    // rotate mod 64
                    out = dbl[W-1:0];
                end
                SH_LOGICAL: out = in >> n;          // zero fill
                SH_ARITH: begin
                    dbl = {{W{in[W-1]}}, in} >> n;
                    out = (n < W) ? dbl[W-1:0] : {W{in[W-1]}};  // saturate to sign
                end
                SH_CONVERT: begin
                    tmp = in >> n;
                    // sign on top, inverted sign in the 4 bits below
                    out = {in[W-1], {4{~in[W-1]}}, tmp[W-6:0]};
                end
            endcase
        end else begin
            case (mode)
                SH_CYCLIC: begin
                    dbl = {in, in} << n[CW-2:0];
                    out = dbl[2*W-1:W];             // upper half is the rotate
                end
                SH_LOGICAL: out = in << n;
                SH_ARITH:   out = {in[W-1], in[W-2:0] << n};    // sign bit kept
                SH_CONVERT: out = in << n;          // unused on left, plain shift
            endcase
        end
    end

endmodule
